// ==== bench/tb_mdu.sv ====
// MDU testbench.
// Table-driven self-checking test of multiply, divide, HI/LO and CP0 behavior.
`timescale 1ns/1ps
`default_nettype none

module tb_mdu
    import mdu_pkg::*;
();

    localparam logic [1:0] CHK_NONE    = 2'd0;
    localparam logic [1:0] CHK_IRQ_SET = 2'd1;
    localparam logic [1:0] CHK_IRQ_CLR = 2'd2;

    // For CHK_IRQ_SET rows the operand a is a margin added to the current Count.
    typedef struct packed {
        alu_op_t    op;
        word_t      a;
        word_t      b;
        cp0_addr_t  sel;
        logic       exc;
        logic [1:0] chk;
    } row_t;

    logic   clk;
    logic   rst_i;
    logic   issue_valid_i;
    issue_t issue_i;
    logic   busy_o;
    logic   valid_o;
    word_t  alures_o;
    dword_t mulres_o;
    logic   resnrdy_o;
    word_t  hi_o;
    word_t  lo_o;
    logic   timer_irq_o;

    row_t   rows[$];
    word_t  lfsr_state;
    word_t  cyc;
    dword_t m_hilo;
    word_t  m_status;
    word_t  m_epc;
    word_t  m_cause;
    word_t  m_compare;
    dword_t hilo_chk;
    logic   hilo_pend;
    logic   tb_ready;
    int     errors;
    int     row_errs;
    int     rows_ok;
    int     rows_bad;

    mdu_top dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .busy_o        (busy_o),
        .valid_o       (valid_o),
        .alures_o      (alures_o),
        .mulres_o      (mulres_o),
        .resnrdy_o     (resnrdy_o),
        .hi_o          (hi_o),
        .lo_o          (lo_o),
        .timer_irq_o   (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Mirrors the CP0 Count register, which is never written here.
    always @(posedge clk) begin
        if (rst_i) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic dword_t model_product(input alu_op_t op, input word_t a, input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        if (op == ALU_MUL || op == ALU_MULT || op == ALU_MADD || op == ALU_MSUB) begin
            sa = $signed(a);
            sb = $signed(b);
            return sa * sb;
        end
        return {32'd0, a} * {32'd0, b};
    endfunction

    // Remainder in the upper half, quotient in the lower half.
    function automatic dword_t model_divide(input logic sgn, input word_t a, input word_t b);
        word_t ma;
        word_t mb;
        word_t q;
        word_t r;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        if (mb == '0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (sgn && (a[31] ^ b[31])) q = -q;
        if (sgn && a[31]) r = -r;
        return {r, q};
    endfunction

    function automatic word_t cp0_expect(input cp0_addr_t sel);
        case (sel)
            CP0_COUNT:   return cyc;
            CP0_COMPARE: return m_compare;
            CP0_STATUS:  return m_status;
            CP0_CAUSE:   return m_cause;
            CP0_EPC:     return m_epc;
            default:     return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input dword_t got, input dword_t exp);
        $display("Fail %s: got %h, expected %h", name, got, exp);
        errors++;
        row_errs++;
    endtask

    task automatic report_problem(input string text);
        $display("Error: %s", text);
        errors++;
        row_errs++;
    endtask

    task automatic compare_hilo();
        if (hilo_pend && hi_o !== hilo_chk[63:32]) report_mismatch("hi_o", hi_o, hilo_chk[63:32]);
        if (hilo_pend && lo_o !== hilo_chk[31:0]) report_mismatch("lo_o", lo_o, hilo_chk[31:0]);
        hilo_pend = 1'b0;
    endtask

    task automatic add_row(input alu_op_t op, input word_t a, input word_t b,
                           input cp0_addr_t sel, input logic exc, input logic [1:0] chk);
        row_t r;
        r.op  = op;
        r.a   = a;
        r.b   = b;
        r.sel = sel;
        r.exc = exc;
        r.chk = chk;
        rows.push_back(r);
    endtask

    task automatic add_op(input alu_op_t op, input word_t a, input word_t b);
        add_row(op, a, b, CP0_ZERO, 1'b0, CHK_NONE);
    endtask

    task automatic add_cp0(input alu_op_t op, input cp0_addr_t sel, input word_t a,
                           input logic exc, input logic [1:0] chk);
        add_row(op, a, '0, sel, exc, chk);
    endtask

    task automatic build_table();
        lfsr_state = 32'he25584bc;
        // Corner multiplies, with MFHI/MFLO issued right behind the write.
        add_op(ALU_MULT,  32'h80000000, 32'h80000000);
        add_op(ALU_MFHI,  '0, '0);
        add_op(ALU_MFLO,  '0, '0);
        add_op(ALU_MULT,  32'h80000000, 32'hffffffff);
        add_op(ALU_MULT,  32'hffffffff, 32'h00000007);
        add_op(ALU_MULTU, 32'hffffffff, 32'hffffffff);
        add_op(ALU_MULTU, 32'h80000000, 32'hffffffff);
        add_op(ALU_MUL,   32'h80000000, 32'h00000003);
        add_op(ALU_MUL,   32'hffffffff, 32'h7fffffff);
        add_op(ALU_MULT,  rand_word(), rand_word());
        add_op(ALU_MULTU, rand_word(), rand_word());
        // Accumulate chain.
        add_op(ALU_MADD,  rand_word(), rand_word());
        add_op(ALU_MADD,  32'hffffffff, 32'h12345678);
        add_op(ALU_MFHI,  '0, '0);
        add_op(ALU_MSUB,  rand_word(), rand_word());
        add_op(ALU_MFLO,  '0, '0);
        add_op(ALU_MADDU, 32'hffffffff, 32'hffffffff);
        add_op(ALU_MSUBU, rand_word(), rand_word());
        add_op(ALU_MFHI,  '0, '0);
        add_op(ALU_MFLO,  '0, '0);
        // Divides, zero divisors included.
        add_op(ALU_DIV,   rand_word(), rand_word() >> 12);
        add_op(ALU_DIVU,  rand_word(), rand_word() >> 12);
        add_op(ALU_DIV,   32'h80000000, 32'hffffffff);
        add_op(ALU_DIV,   32'hfffffff9, 32'h00000002);
        add_op(ALU_DIV,   32'hffffff85, 32'h00000000);
        add_op(ALU_DIVU,  32'h12345678, 32'h00000000);
        add_op(ALU_MFHI,  '0, '0);
        add_op(ALU_MTHI,  32'hcafef00d, '0);
        add_op(ALU_MTLO,  32'h0badc0de, '0);
        // CP0 access.
        add_cp0(ALU_MFC0, CP0_CAUSE,   '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MTC0, CP0_STATUS,  32'h0000ff01, 1'b0, CHK_NONE);
        add_cp0(ALU_MFC0, CP0_STATUS,  '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MTC0, CP0_EPC,     32'hbfc00180, 1'b0, CHK_NONE);
        add_cp0(ALU_MFC0, CP0_EPC,     '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MTC0, CP0_EPC,     32'h11111111, 1'b1, CHK_NONE);
        add_cp0(ALU_MFC0, CP0_EPC,     '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MTC0, 5'd3,        32'h5a5a5a5a, 1'b0, CHK_NONE);
        add_cp0(ALU_MFC0, 5'd3,        '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MFC0, CP0_COUNT,   '0, 1'b0, CHK_NONE);
        add_op(ALU_ADD,   rand_word(), rand_word());
        add_cp0(ALU_MFC0, CP0_COUNT,   '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MTC0, CP0_COMPARE, 32'd20, 1'b0, CHK_IRQ_SET);
        add_cp0(ALU_MFC0, CP0_COMPARE, '0, 1'b0, CHK_NONE);
        add_cp0(ALU_MTC0, CP0_COMPARE, '0, 1'b0, CHK_IRQ_CLR);
        // Loads only pass their address.
        add_op(ALU_LW,    rand_word(), 32'h00000040);
        add_op(ALU_LB,    rand_word(), 32'hfffffffc);
        add_op(ALU_LHU,   rand_word(), rand_word());
        add_op(ALU_LWL,   32'hfffffffe, 32'h00000003);
        add_op(ALU_LL,    rand_word(), 32'h00000010);
    endtask

    initial begin
        int limit_ns;
        wait (tb_ready === 1'b1);
        limit_ns = (rows.size() + 1) * (DIV_STEPS + 10) * 10;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Verification failed");
        $finish;
    end

    initial begin
        row_t   r;
        word_t  opa;
        word_t  exp_alu;
        logic   chk_alu;
        logic   exp_nrdy;
        dword_t prod;
        int     lat;
        int     wait_n;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        m_hilo        = '0;
        m_status      = '0;
        m_epc         = '0;
        m_cause       = '0;
        m_compare     = '0;
        hilo_pend     = 1'b0;
        errors        = 0;
        rows_ok       = 0;
        rows_bad      = 0;
        build_table();
        tb_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;
        if (busy_o !== 1'b0 || valid_o !== 1'b0 || timer_irq_o !== 1'b0) begin
            report_problem("control outputs not low after reset");
        end
        if (hi_o !== '0 || lo_o !== '0) report_problem("HI/LO not cleared by reset");

        for (int i = 0; i < rows.size(); i++) begin
            r        = rows[i];
            row_errs = 0;
            opa      = (r.chk == CHK_IRQ_SET) ? cyc + r.a : r.a;
            issue_valid_i    = 1'b1;
            issue_i.aluop    = r.op;
            issue_i.opa      = opa;
            issue_i.opb      = r.b;
            issue_i.cp0sel   = r.sel;
            issue_i.exc_flag = r.exc;
            @(posedge clk);
            #1;
            issue_valid_i = 1'b0;
            compare_hilo();

            if (r.op == ALU_DIV || r.op == ALU_DIVU) begin
                // An MTLO offered during busy has to be dropped.
                lat = 0;
                while (valid_o !== 1'b1 && lat < DIV_STEPS + 8) begin
                    if (busy_o !== 1'b1) report_mismatch("busy_o", busy_o, 1);
                    issue_valid_i = (lat == 0);
                    issue_i.aluop = ALU_MTLO;
                    issue_i.opa   = 32'hdeadbeef;
                    @(posedge clk);
                    #1;
                    lat++;
                end
                issue_valid_i = 1'b0;
                if (valid_o === 1'b1 && lat != DIV_STEPS + 2) begin
                    report_problem($sformatf("divide took %0d cycles instead of %0d",
                                             lat, DIV_STEPS + 2));
                end
                if (busy_o !== 1'b0) report_mismatch("busy_o", busy_o, 0);
            end

            if (valid_o !== 1'b1) report_mismatch("valid_o", valid_o, 1);
            exp_nrdy = (r.op == ALU_MUL) || (r.op >= ALU_LB && r.op <= ALU_LL);
            if (resnrdy_o !== exp_nrdy) report_mismatch("resnrdy_o", resnrdy_o, exp_nrdy);
            prod = model_product(r.op, opa, r.b);
            if (r.op >= ALU_MUL && r.op <= ALU_MSUBU && mulres_o !== prod) begin
                report_mismatch("mulres_o", mulres_o, prod);
            end

            chk_alu = 1'b1;
            case (r.op)
                ALU_MFHI: exp_alu = m_hilo[63:32];
                ALU_MFLO: exp_alu = m_hilo[31:0];
                ALU_MFC0: exp_alu = cp0_expect(r.sel);
                ALU_ADD, ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
                ALU_LW, ALU_LWL, ALU_LWR, ALU_LL: exp_alu = opa + r.b;
                default: chk_alu = 1'b0;
            endcase
            if (chk_alu && alures_o !== exp_alu) report_mismatch("alures_o", alures_o, exp_alu);

            // With Compare at zero the timer stays quiet.
            if (m_compare == '0 && timer_irq_o !== 1'b0) begin
                report_mismatch("timer_irq_o", timer_irq_o, 0);
            end

            case (r.op)
                ALU_MULT, ALU_MULTU: m_hilo = prod;
                ALU_MADD, ALU_MADDU: m_hilo = m_hilo + prod;
                ALU_MSUB, ALU_MSUBU: m_hilo = m_hilo - prod;
                ALU_DIV:  m_hilo = model_divide(1'b1, opa, r.b);
                ALU_DIVU: m_hilo = model_divide(1'b0, opa, r.b);
                ALU_MTHI: m_hilo[63:32] = opa;
                ALU_MTLO: m_hilo[31:0] = opa;
                ALU_MTC0: begin
                    if (!r.exc && r.sel == CP0_STATUS)  m_status  = opa;
                    if (!r.exc && r.sel == CP0_EPC)     m_epc     = opa;
                    if (!r.exc && r.sel == CP0_CAUSE)   m_cause   = opa;
                    if (!r.exc && r.sel == CP0_COMPARE) m_compare = opa;
                end
                default: ;
            endcase
            hilo_chk  = m_hilo;
            hilo_pend = 1'b1;

            // Compare writes land at the next edge and always clear the interrupt.
            if (r.chk != CHK_NONE) begin
                @(posedge clk);
                #1;
                compare_hilo();
                if (timer_irq_o !== 1'b0) report_mismatch("timer_irq_o", timer_irq_o, 0);
                if (r.chk == CHK_IRQ_SET) begin
                    wait_n = 0;
                    while (timer_irq_o !== 1'b1 && wait_n < r.a + 10) begin
                        @(posedge clk);
                        #1;
                        wait_n++;
                    end
                    // The flag registers the cycle in which Count equals Compare.
                    if (timer_irq_o !== 1'b1) begin
                        report_problem("timer interrupt never rose");
                    end else if (cyc !== opa + 32'd1) begin
                        report_problem("timer interrupt rose at the wrong Count value");
                    end
                end
            end

            if (row_errs == 0) begin
                rows_ok++;
                $display("Test %0d op %h: ok", i, r.op);
            end else begin
                rows_bad++;
                $display("Test %0d op %h: %0d mismatches", i, r.op, row_errs);
            end
        end

        @(posedge clk);
        #1;
        compare_hilo();
        $display("Tests: %0d, ok: %0d, bad: %0d, errors: %0d",
                 rows.size(), rows_ok, rows_bad, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/mdu_pkg.sv ====
// MDU shared definitions.
// Widths, operation codes, CP0 register numbers and pipeline bundles.
`default_nettype none

package mdu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [5:0]  alu_op_t;
    typedef logic [4:0]  cp0_addr_t;

    localparam alu_op_t ALU_NOP   = 6'h00;
    localparam alu_op_t ALU_ADD   = 6'h01;
    localparam alu_op_t ALU_MUL   = 6'h02;
    localparam alu_op_t ALU_MULT  = 6'h03;
    localparam alu_op_t ALU_MULTU = 6'h04;
    localparam alu_op_t ALU_MADD  = 6'h05;
    localparam alu_op_t ALU_MADDU = 6'h06;
    localparam alu_op_t ALU_MSUB  = 6'h07;
    localparam alu_op_t ALU_MSUBU = 6'h08;
    localparam alu_op_t ALU_DIV   = 6'h09;
    localparam alu_op_t ALU_DIVU  = 6'h0a;
    localparam alu_op_t ALU_MFHI  = 6'h0b;
    localparam alu_op_t ALU_MFLO  = 6'h0c;
    localparam alu_op_t ALU_MTHI  = 6'h0d;
    localparam alu_op_t ALU_MTLO  = 6'h0e;
    localparam alu_op_t ALU_MFC0  = 6'h0f;
    localparam alu_op_t ALU_MTC0  = 6'h10;
    localparam alu_op_t ALU_LB    = 6'h11;
    localparam alu_op_t ALU_LBU   = 6'h12;
    localparam alu_op_t ALU_LH    = 6'h13;
    localparam alu_op_t ALU_LHU   = 6'h14;
    localparam alu_op_t ALU_LW    = 6'h15;
    localparam alu_op_t ALU_LWL   = 6'h16;
    localparam alu_op_t ALU_LWR   = 6'h17;
    localparam alu_op_t ALU_LL    = 6'h18;

    localparam cp0_addr_t CP0_ZERO    = 5'd0;
    localparam cp0_addr_t CP0_COUNT   = 5'd9;
    localparam cp0_addr_t CP0_COMPARE = 5'd11;
    localparam cp0_addr_t CP0_STATUS  = 5'd12;
    localparam cp0_addr_t CP0_CAUSE   = 5'd13;
    localparam cp0_addr_t CP0_EPC     = 5'd14;

    // One quotient bit per iteration.
    localparam int DIV_STEPS = 32;

    typedef struct packed {
        alu_op_t   aluop;
        word_t     opa;
        word_t     opb;
        cp0_addr_t cp0sel;
        logic      exc_flag;
    } issue_t;

    // Partial products: mullo = {aH*bL, aL*bL}, mulhi = {aH*bH, aL*bH}.
    typedef struct packed {
        alu_op_t   aluop;
        word_t     alures;
        dword_t    mulhi;
        dword_t    mullo;
        logic      mul_s;
        dword_t    divres;
        cp0_addr_t cp0sel;
        logic      exc_flag;
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== cp0/cp0_regs.sv ====
// CP0 register set with Count/Compare timer interrupt.
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import mdu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      wen_i,
    input  cp0_addr_t addr_i,
    input  word_t     wdata_i,
    output word_t     rdata_o,
    output logic      timer_irq_o
);

    word_t count;
    word_t compare;
    word_t status;
    word_t cause;
    word_t epc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count   <= '0;
            compare <= '0;
            status  <= '0;
            cause   <= '0;
            epc     <= '0;
        end else begin
            // A software write to Count wins over the tick.
            if (wen_i && addr_i == CP0_COUNT) begin
                count <= wdata_i;
            end else begin
                count <= count + 32'd1;
            end
            if (wen_i && addr_i == CP0_COMPARE) compare <= wdata_i;
            if (wen_i && addr_i == CP0_STATUS)  status  <= wdata_i;
            if (wen_i && addr_i == CP0_CAUSE)   cause   <= wdata_i;
            if (wen_i && addr_i == CP0_EPC)     epc     <= wdata_i;
        end
    end

    // Writing Compare acknowledges the timer.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            timer_irq_o <= 1'b0;
        end else if (wen_i && addr_i == CP0_COMPARE) begin
            timer_irq_o <= 1'b0;
        end else if (compare != '0 && count == compare) begin
            timer_irq_o <= 1'b1;
        end
    end

    always_comb begin
        case (addr_i)
            CP0_COUNT:   rdata_o = count;
            CP0_COMPARE: rdata_o = compare;
            CP0_STATUS:  rdata_o = status;
            CP0_CAUSE:   rdata_o = cause;
            CP0_EPC:     rdata_o = epc;
            default:     rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== divider/div_unit.sv ====
// Iterative restoring divider.
// One quotient bit per cycle on magnitudes, sign fixed at the end.
`timescale 1ns/1ps
`default_nettype none

module div_unit
    import mdu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_i,
    input  logic   start_i,
    input  word_t  a_i,
    input  word_t  b_i,
    input  logic   signed_i,
    output logic   busy_o,
    output logic   done_o,
    output dword_t divres_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FIX
    } div_state_t;

    div_state_t  state;
    logic [4:0]  step;
    logic        launch;
    word_t       divisor;
    word_t       quot;
    word_t       rem;
    logic        neg_q;
    logic        neg_r;
    logic [32:0] shifted;
    logic [32:0] diff;

    assign launch = (state == S_IDLE) && start_i;

    // Busy covers the done cycle so nothing collides with the result.
    assign busy_o = (state != S_IDLE) || done_o;

    assign shifted = {rem, quot[31]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state  <= S_IDLE;
            step   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state <= S_RUN;
                        step  <= '0;
                    end
                end
                S_RUN: begin
                    step <= step + 5'd1;
                    if (step == 5'(DIV_STEPS - 1)) begin
                        state <= S_FIX;
                    end
                end
                S_FIX: begin
                    state  <= S_IDLE;
                    done_o <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // A zero divisor never underflows, giving all-ones quotient and remainder = dividend.
    always_ff @(posedge clk) begin
        if (launch) begin
            quot    <= (signed_i && a_i[31]) ? -a_i : a_i;
            divisor <= (signed_i && b_i[31]) ? -b_i : b_i;
            rem     <= '0;
            neg_q   <= signed_i && (a_i[31] ^ b_i[31]);
            neg_r   <= signed_i && a_i[31];
        end else if (state == S_RUN) begin
            if (!diff[32]) begin
                rem  <= diff[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem  <= shifted[31:0];
                quot <= {quot[30:0], 1'b0};
            end
        end else if (state == S_FIX) begin
            divres_o <= {(neg_r ? -rem : rem), (neg_q ? -quot : quot)};
        end
    end

endmodule

`default_nettype wire

// ==== source/alu_mem.sv ====
// Memory-stage completion for multiply, divide and CP0 operations.
// Builds the product, updates HI/LO and drives the CP0 access.
`timescale 1ns/1ps
`default_nettype none

module alu_mem
    import mdu_pkg::*;
(
    input  ex_mem_t   mem_i,
    input  dword_t    hilo_i,
    output word_t     alures_o,
    output dword_t    mulres_o,
    output logic      hilo_wen_o,
    output dword_t    hilo_o,
    output logic      cp0_wen_o,
    output cp0_addr_t cp0_addr_o,
    output word_t     cp0_wdata_o,
    input  word_t     cp0_rdata_i,
    output logic      resnrdy_o
);

    logic [47:0] sum_lo;
    logic [47:0] sum_hi;
    dword_t      umres;
    dword_t      smres;

    // Shifted sum of the four partial products.
    assign sum_lo = {16'd0, mem_i.mullo[31:0]} + {mem_i.mullo[63:32], 16'd0};
    assign sum_hi = {16'd0, mem_i.mulhi[31:0]} + {mem_i.mulhi[63:32], 16'd0};
    assign umres  = {16'd0, sum_lo} + {sum_hi, 16'd0};
    assign smres  = mem_i.mul_s ? -umres : umres;

    assign mulres_o = smres;

    always_comb begin
        hilo_wen_o  = 1'b0;
        hilo_o      = hilo_i;
        alures_o    = mem_i.alures;
        cp0_wen_o   = 1'b0;
        cp0_addr_o  = CP0_ZERO;
        cp0_wdata_o = '0;

        case (mem_i.aluop)
            ALU_MFHI: alures_o = hilo_i[63:32];
            ALU_MFLO: alures_o = hilo_i[31:0];
            ALU_MTHI: begin
                hilo_wen_o = 1'b1;
                hilo_o     = {mem_i.alures, hilo_i[31:0]};
            end
            ALU_MTLO: begin
                hilo_wen_o = 1'b1;
                hilo_o     = {hilo_i[63:32], mem_i.alures};
            end
            ALU_MULT: begin
                hilo_wen_o = 1'b1;
                hilo_o     = smres;
            end
            ALU_MULTU: begin
                hilo_wen_o = 1'b1;
                hilo_o     = umres;
            end
            ALU_MADD: begin
                hilo_wen_o = 1'b1;
                hilo_o     = hilo_i + smres;
            end
            ALU_MADDU: begin
                hilo_wen_o = 1'b1;
                hilo_o     = hilo_i + umres;
            end
            ALU_MSUB: begin
                hilo_wen_o = 1'b1;
                hilo_o     = hilo_i - smres;
            end
            ALU_MSUBU: begin
                hilo_wen_o = 1'b1;
                hilo_o     = hilo_i - umres;
            end
            ALU_DIV, ALU_DIVU: begin
                hilo_wen_o = 1'b1;
                hilo_o     = mem_i.divres;
            end
            ALU_MFC0: begin
                cp0_addr_o = mem_i.cp0sel;
                alures_o   = cp0_rdata_i;
            end
            ALU_MTC0: begin
                // A pending exception cancels the write.
                cp0_addr_o  = mem_i.cp0sel;
                cp0_wen_o   = !mem_i.exc_flag;
                cp0_wdata_o = mem_i.alures;
            end
            default: ;
        endcase
    end

    // Loads and MUL finish in a later stage.
    always_comb begin
        case (mem_i.aluop)
            ALU_MUL, ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
            ALU_LW, ALU_LWL, ALU_LWR, ALU_LL: resnrdy_o = 1'b1;
            default:                          resnrdy_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mdu_ex.sv ====
// MDU execute stage.
// Prepares partial products, launches divides, holds HI/LO and the memory-stage register.
`timescale 1ns/1ps
`default_nettype none

module mdu_ex
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    issue_valid_i,
    input  issue_t  issue_i,
    input  logic    div_busy_i,
    input  logic    div_done_i,
    input  dword_t  divres_i,
    output logic    div_start_o,
    output word_t   div_a_o,
    output word_t   div_b_o,
    output logic    div_signed_o,
    input  logic    hilo_wen_i,
    input  dword_t  hilo_new_i,
    output ex_mem_t mem_stage_o,
    output logic    mem_valid_o,
    output dword_t  hilo_o
);

    logic    accept;
    logic    is_div;
    logic    mul_signed;
    word_t   mag_a;
    word_t   mag_b;
    word_t   pp_ll;
    word_t   pp_hl;
    word_t   pp_lh;
    word_t   pp_hh;
    ex_mem_t ex_bundle;
    alu_op_t div_op;

    // Issues arriving while the divider is busy are dropped.
    assign accept = issue_valid_i && !div_busy_i;
    assign is_div = (issue_i.aluop == ALU_DIV) || (issue_i.aluop == ALU_DIVU);

    assign div_start_o  = accept && is_div;
    assign div_a_o      = issue_i.opa;
    assign div_b_o      = issue_i.opb;
    assign div_signed_o = (issue_i.aluop == ALU_DIV);

    always_comb begin
        case (issue_i.aluop)
            ALU_MUL, ALU_MULT, ALU_MADD, ALU_MSUB: mul_signed = 1'b1;
            default:                              mul_signed = 1'b0;
        endcase
    end

    // Signed multiplies work on magnitudes.
    assign mag_a = (mul_signed && issue_i.opa[31]) ? -issue_i.opa : issue_i.opa;
    assign mag_b = (mul_signed && issue_i.opb[31]) ? -issue_i.opb : issue_i.opb;

    assign pp_ll = mag_a[15:0]  * mag_b[15:0];
    assign pp_hl = mag_a[31:16] * mag_b[15:0];
    assign pp_lh = mag_a[15:0]  * mag_b[31:16];
    assign pp_hh = mag_a[31:16] * mag_b[31:16];

    always_comb begin
        ex_bundle          = '0;
        ex_bundle.aluop    = issue_i.aluop;
        ex_bundle.mulhi    = {pp_hh, pp_lh};
        ex_bundle.mullo    = {pp_hl, pp_ll};
        ex_bundle.mul_s    = mul_signed && (issue_i.opa[31] ^ issue_i.opb[31]);
        ex_bundle.cp0sel   = issue_i.cp0sel;
        ex_bundle.exc_flag = issue_i.exc_flag;
        case (issue_i.aluop)
            ALU_ADD, ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
            ALU_LW, ALU_LWL, ALU_LWR, ALU_LL:
                ex_bundle.alures = issue_i.opa + issue_i.opb;
            ALU_MTHI, ALU_MTLO, ALU_MTC0:
                ex_bundle.alures = issue_i.opa;
            default:
                ex_bundle.alures = '0;
        endcase
    end

    // Remember which divide is in flight.
    always_ff @(posedge clk) begin
        if (div_start_o) begin
            div_op <= issue_i.aluop;
        end
    end

    // An empty slot carries a NOP so the completion logic stays idle.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_valid_o       <= 1'b0;
            mem_stage_o.aluop <= ALU_NOP;
        end else if (div_done_i) begin
            mem_valid_o <= 1'b1;
            mem_stage_o <= '{aluop: div_op, divres: divres_i, default: '0};
        end else if (accept && !is_div) begin
            mem_valid_o <= 1'b1;
            mem_stage_o <= ex_bundle;
        end else begin
            mem_valid_o       <= 1'b0;
            mem_stage_o.aluop <= ALU_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_o <= '0;
        end else if (mem_valid_o && hilo_wen_i) begin
            hilo_o <= hilo_new_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/mdu_top.sv ====
// MDU and CP0 back end top level.
// Connects the execute stage, divider, completion logic and CP0 registers.
`timescale 1ns/1ps
`default_nettype none

module mdu_top
    import mdu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_i,
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    output logic   busy_o,
    output logic   valid_o,
    output word_t  alures_o,
    output dword_t mulres_o,
    output logic   resnrdy_o,
    output word_t  hi_o,
    output word_t  lo_o,
    output logic   timer_irq_o
);

    logic      div_start;
    word_t     div_a;
    word_t     div_b;
    logic      div_signed;
    logic      div_busy;
    logic      div_done;
    dword_t    divres;
    ex_mem_t   mem_stage;
    dword_t    hilo;
    logic      hilo_wen;
    dword_t    hilo_new;
    logic      cp0_wen;
    cp0_addr_t cp0_addr;
    word_t     cp0_wdata;
    word_t     cp0_rdata;

    assign busy_o = div_busy;
    assign hi_o   = hilo[63:32];
    assign lo_o   = hilo[31:0];

    mdu_ex u_ex (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .div_busy_i    (div_busy),
        .div_done_i    (div_done),
        .divres_i      (divres),
        .div_start_o   (div_start),
        .div_a_o       (div_a),
        .div_b_o       (div_b),
        .div_signed_o  (div_signed),
        .hilo_wen_i    (hilo_wen),
        .hilo_new_i    (hilo_new),
        .mem_stage_o   (mem_stage),
        .mem_valid_o   (valid_o),
        .hilo_o        (hilo)
    );

    div_unit u_div (
        .clk      (clk),
        .rst_i    (rst_i),
        .start_i  (div_start),
        .a_i      (div_a),
        .b_i      (div_b),
        .signed_i (div_signed),
        .busy_o   (div_busy),
        .done_o   (div_done),
        .divres_o (divres)
    );

    alu_mem u_mem (
        .mem_i       (mem_stage),
        .hilo_i      (hilo),
        .alures_o    (alures_o),
        .mulres_o    (mulres_o),
        .hilo_wen_o  (hilo_wen),
        .hilo_o      (hilo_new),
        .cp0_wen_o   (cp0_wen),
        .cp0_addr_o  (cp0_addr),
        .cp0_wdata_o (cp0_wdata),
        .cp0_rdata_i (cp0_rdata),
        .resnrdy_o   (resnrdy_o)
    );

    cp0_regs u_cp0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .wen_i       (cp0_wen),
        .addr_i      (cp0_addr),
        .wdata_i     (cp0_wdata),
        .rdata_o     (cp0_rdata),
        .timer_irq_o (timer_irq_o)
    );

endmodule

`default_nettype wire

// ==== verilog.f ====
common/mdu_pkg.sv
divider/div_unit.sv
cp0/cp0_regs.sv
source/mdu_ex.sv
source/alu_mem.sv
source/mdu_top.sv
bench/tb_mdu.sv
